// File: common/counter_display_pkg.sv
package counter_display_pkg;

  // ------------------------------
  // Display geometry
  // ------------------------------

  // One decimal (or up to hex) digit
  localparam int digit_width = 4;

  // Segments per display, decimal point not driven
  localparam int seg_width = 7;

  // Segment word, active low
  //      0
  //    5   1
  //      6
  //    4   2
  //      3
  // Bit 0 top, 1..5 clockwise, 6 middle
  typedef logic [seg_width-1:0] seg_t;

  // ------------------------------
  // Top-level defaults
  // ------------------------------

  // Counter width, wraps at 256
  localparam int default_count_width = 8;

  // Three displays cover 0..255 in decimal
  localparam int default_num_digits = 3;

  // Conversion base, at most 16 with 4-bit digits
  localparam int default_base = 10;

endpackage

// File: verilog/key_counter.sv
`timescale 1ns/1ns

module key_counter #(
  parameter int count_width = counter_display_pkg::default_count_width
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [1:0]             keys,   // Active low, 0 up, 1 down
  output logic [count_width-1:0] count
);

  // ------------------------------
  // Key synchroniser
  // ------------------------------

  logic [1:0] key_meta;  // First flop, may go metastable
  logic [1:0] key_sync;  // Second flop, safe level
  logic [1:0] key_prev;  // Last cycle's synced level
  logic [1:0] press;     // One-cycle press strobes
  logic       step_up;
  logic       step_down;

  always_ff @(posedge clk) begin
    if (reset) begin
      key_meta <= 2'b11;  // Released keys read high
      key_sync <= 2'b11;
      key_prev <= 2'b11;
    end else begin
      key_meta <= keys;
      key_sync <= key_meta;
      key_prev <= key_sync;
    end
  end

  // Press is a high-to-low transition of the synced level
  assign press = key_prev & ~key_sync;

  assign step_up   = press[0];
  assign step_down = press[1];

  // ------------------------------
  // Up/down count
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (step_up) begin         // Up wins on a tie
      count <= count + 1'b1;            // Wraps to zero
    end else if (step_down) begin
      count <= count - 1'b1;            // Wraps to all ones
    end
  end

endmodule

// File: notation/seq_divider.sv
`timescale 1ns/1ns

module seq_divider #(
  parameter int count_width = counter_display_pkg::default_count_width,
  parameter int base        = counter_display_pkg::default_base
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,      // Held high for the whole division
  input  logic [count_width-1:0] dividend,
  output logic                   done,       // High until start drops
  output logic [count_width-1:0] quotient,
  output logic [count_width-1:0] remainder
);

  // Remainder half must hold +-2*base as a signed value
  localparam int rem_width  = (count_width > $clog2(base) + 2) ? count_width : $clog2(base) + 2;
  localparam int acc_width  = rem_width + count_width;
  localparam int step_width = $clog2(count_width + 1);
  localparam logic [rem_width-1:0] divisor = rem_width'(base);

  logic [acc_width-1:0]  acc;          // Partial remainder : dividend bits
  logic [step_width-1:0] steps;        // Steps left, 0 when idle
  logic [acc_width-1:0]  acc_shifted;
  logic [rem_width-1:0]  rem_shifted;
  logic [rem_width-1:0]  rem_step;     // After add or subtract
  logic [rem_width-1:0]  rem_fixed;    // After final correction
  logic                  q_bit;

  // ------------------------------
  // One non-restoring step
  // ------------------------------

  assign acc_shifted = acc << 1;
  assign rem_shifted = acc_shifted[acc_width-1 -: rem_width];

  // Negative partial remainder adds the divisor back, else subtract
  assign rem_step  = rem_shifted[rem_width-1] ? rem_shifted + divisor : rem_shifted - divisor;
  assign rem_fixed = rem_step[rem_width-1] ? rem_step + divisor : rem_step;
  assign q_bit     = ~rem_step[rem_width-1];  // Non-negative result gives a one

  assign remainder = acc[count_width +: count_width];  // Never wider than the dividend

  // Control
  always_ff @(posedge clk) begin
    if (reset) begin
      done  <= 1'b0;
      steps <= '0;
    end else if (!start) begin
      done  <= 1'b0;                    // Drop of start clears the result flag
      steps <= '0;
    end else if (!done) begin
      if (steps == '0) begin
        steps <= step_width'(count_width);  // Load cycle
      end else begin
        steps <= steps - 1'b1;
        if (steps == step_width'(1)) begin
          done <= 1'b1;
        end
      end
    end
  end

  // Datapath
  always_ff @(posedge clk) begin
    if (start && !done) begin
      if (steps == '0) begin
        acc <= {{rem_width{1'b0}}, dividend};
      end else begin
        if (steps == step_width'(1)) begin
          acc <= {rem_fixed, acc_shifted[count_width-1:0]};  // Last step corrects
        end else begin
          acc <= {rem_step, acc_shifted[count_width-1:0]};
        end
        quotient <= {quotient[count_width-2:0], q_bit};
      end
    end
  end

endmodule

// File: notation/decimal_converter.sv
`timescale 1ns/1ns

module decimal_converter #(
  parameter int count_width = counter_display_pkg::default_count_width,
  parameter int num_digits  = counter_display_pkg::default_num_digits,
  parameter int base        = counter_display_pkg::default_base
) (
  input  logic                                              clk,
  input  logic                                              reset,
  input  logic [count_width-1:0]                            number,
  output logic [num_digits*counter_display_pkg::digit_width-1:0] digits  // Digit 0 in low bits
);

  import counter_display_pkg::*;

  localparam int idx_width = (num_digits > 1) ? $clog2(num_digits) : 1;

  // ------------------------------
  // FSM encoding
  // ------------------------------
  localparam logic [1:0] st_load    = 2'd0;  // Sample number
  localparam logic [1:0] st_divide  = 2'd1;  // Divider busy
  localparam logic [1:0] st_wait    = 2'd2;  // Let done fall
  localparam logic [1:0] st_publish = 2'd3;  // Copy digits out

  logic [1:0]             state;
  logic [idx_width-1:0]   idx;                      // Digit being produced
  logic                   start;                    // Level to the divider
  logic                   div_done;
  logic [count_width-1:0] current;                  // Running dividend
  logic [count_width-1:0] quotient;
  logic [count_width-1:0] remainder;
  logic [digit_width-1:0] work [num_digits];        // Digits of this pass

  seq_divider #(
    .count_width (count_width),
    .base        (base)
  ) divider_i (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .dividend  (current),
    .done      (div_done),
    .quotient  (quotient),
    .remainder (remainder)
  );

  // Control and published digits
  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= st_load;
      idx    <= '0;
      start  <= 1'b0;
      digits <= '0;
    end else begin
      case (state)
        st_load: begin
          idx   <= '0;
          start <= 1'b1;
          state <= st_divide;
        end
        st_divide: begin
          if (div_done) begin
            start <= 1'b0;  // Only dropped once the result is in
            state <= st_wait;
          end
        end
        st_wait: begin
          if (idx == idx_width'(num_digits - 1)) begin
            state <= st_publish;
          end else begin
            idx   <= idx + 1'b1;
            start <= 1'b1;  // Divider saw start low last edge, so it reloads
            state <= st_divide;
          end
        end
        default: begin  // st_publish
          for (int i = 0; i < num_digits; i++) begin
            digits[i*digit_width +: digit_width] <= work[i];
          end
          state <= st_load;  // Free-running, start over
        end
      endcase
    end
  end

  // Working dividend and digit array
  always_ff @(posedge clk) begin
    if (state == st_load) begin
      current <= number;
    end else if (state == st_divide && div_done) begin
      work[idx] <= digit_width'(remainder);  // Remainder is below base
      current   <= quotient;                 // Next dividend
    end
  end

endmodule

// File: verilog/seven_seg_decoder.sv
`timescale 1ns/1ns

module seven_seg_decoder (
  input  logic [counter_display_pkg::digit_width-1:0] digit,
  output counter_display_pkg::seg_t                   seg    // Active low
);

  import counter_display_pkg::*;

  seg_t lit;  // Active-high pattern, bit order 6543210

  // ------------------------------
  // Hex lookup table
  // ------------------------------
  always_comb begin
    case (digit)
      4'h0:    lit = 7'b0111111;
      4'h1:    lit = 7'b0000110;
      4'h2:    lit = 7'b1011011;
      4'h3:    lit = 7'b1001111;
      4'h4:    lit = 7'b1100110;
      4'h5:    lit = 7'b1101101;
      4'h6:    lit = 7'b1111101;
      4'h7:    lit = 7'b0000111;
      4'h8:    lit = 7'b1111111;
      4'h9:    lit = 7'b1101111;
      4'ha:    lit = 7'b1110111;  // A
      4'hb:    lit = 7'b1111100;  // b, lower case
      4'hc:    lit = 7'b0111001;  // C
      4'hd:    lit = 7'b1011110;  // d, lower case
      4'he:    lit = 7'b1111001;  // E
      default: lit = 7'b1110001;  // F
    endcase
  end

  // Board displays light on a low level
  assign seg = ~lit;

endmodule

// File: verilog/counter_display_top.sv
`timescale 1ns/1ns

module counter_display_top #(
  parameter int count_width = counter_display_pkg::default_count_width,
  parameter int num_digits  = counter_display_pkg::default_num_digits,
  parameter int base        = counter_display_pkg::default_base
) (
  input  logic                                       clk,
  input  logic                                       reset,
  input  logic [1:0]                                 keys,   // Active low, 0 up, 1 down
  output logic [count_width-1:0]                     count,
  output counter_display_pkg::seg_t [num_digits-1:0] hex     // Digit 0 least significant
);

  import counter_display_pkg::*;

  logic [num_digits*digit_width-1:0] digits;  // Last complete conversion

  // ------------------------------
  // Counter and converter
  // ------------------------------

  key_counter #(
    .count_width (count_width)
  ) key_counter_i (
    .clk   (clk),
    .reset (reset),
    .keys  (keys),
    .count (count)
  );

  decimal_converter #(
    .count_width (count_width),
    .num_digits  (num_digits),
    .base        (base)
  ) converter_i (
    .clk    (clk),
    .reset  (reset),
    .number (count),
    .digits (digits)
  );

  // One decoder per display
  for (genvar g = 0; g < num_digits; g++) begin : gen_display
    seven_seg_decoder decoder_i (
      .digit (digits[g*digit_width +: digit_width]),
      .seg   (hex[g])
    );
  end

endmodule

// File: tb/counter_display_assertions.sv
`timescale 1ns/1ns

module counter_display_assertions #(
  parameter int num_digits = counter_display_pkg::default_num_digits,
  parameter int base       = counter_display_pkg::default_base
) (
  input logic                                                    clk,
  input logic                                                    reset,
  input logic                                                    start,     // Divider level
  input logic                                                    div_done,
  input logic [1:0]                                              state,     // Converter FSM
  input logic [num_digits*counter_display_pkg::digit_width-1:0] digits
);

  import counter_display_pkg::*;

  localparam logic [1:0] publish_state = 2'd3;

  logic digits_ok;  // Every published digit below base

  always_comb begin
    digits_ok = 1'b1;
    for (int i = 0; i < num_digits; i++) begin
      if (digits[i*digit_width +: digit_width] >= base) begin
        digits_ok = 1'b0;
      end
    end
  end

  // ------------------------------
  // Converter properties
  // ------------------------------

  // Start only falls once the divider has finished
  start_held: assert property (@(posedge clk) disable iff (reset)
    $fell(start) |-> $past(div_done))
    else $error("divider start dropped before done");

  digit_range: assert property (@(posedge clk) disable iff (reset) digits_ok)
    else $error("published digit not below base");

  // Output word moves only right after the publish state
  publish_only: assert property (@(posedge clk) disable iff (reset)
    !$stable(digits) |-> $past(state) == publish_state)
    else $error("digits changed outside the publish step");

endmodule

// File: tb/counter_display_tb.sv
`timescale 1ns/1ns

module counter_display_tb;

  import counter_display_pkg::*;

  // One row of the stimulus table
  typedef struct {
    string      name;
    logic [1:0] keys;       // Active low, held for the step
    int         hold;       // Cycles held, 0 draws a random time
    int         exp_count;  // Count expected after the step
  } step_t;

  logic       clk;
  logic       reset;
  logic [1:0] keys;
  logic [7:0] count;
  seg_t [2:0] hex;          // Digit 0 in the low bits

  step_t  table_rows[$];
  integer seed;             // Seed for random hold times

  counter_display_top dut_i (
    .clk   (clk),
    .reset (reset),
    .keys  (keys),
    .count (count),
    .hex   (hex)
  );

  // Converter checks, attached inside every converter instance
  bind decimal_converter counter_display_assertions #(
    .num_digits (num_digits),
    .base       (base)
  ) assertions_i (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .div_done (div_done),
    .state    (state),
    .digits   (digits)
  );

  // ------------------------------
  // Clock, 20 ns period
  // ------------------------------
  initial begin
    clk = 1'b0;
    forever begin
      #10;
      clk = ~clk;
    end
  end

  // Active-low segment codes for decimal digits
  function automatic seg_t seg_pattern(input int digit);
    case (digit)
      0:       return 7'b1000000;
      1:       return 7'b1111001;
      2:       return 7'b0100100;
      3:       return 7'b0110000;
      4:       return 7'b0011001;
      5:       return 7'b0010010;
      6:       return 7'b0000010;
      7:       return 7'b1111000;
      8:       return 7'b0000000;
      default: return 7'b0010000;  // 9
    endcase
  endfunction

  // Three displays for a value, least significant digit first
  function automatic logic [20:0] expected_hex(input int value);
    logic [20:0] pattern;
    int          rest;
    rest = value;
    for (int i = 0; i < 3; i++) begin
      pattern[i*7 +: 7] = seg_pattern(rest % 10);
      rest = rest / 10;                  // Next decimal place
    end
    return pattern;
  endfunction

  task automatic add_step(input string name, input logic [1:0] k, input int hold,
                          input int exp_count);
    step_t row;
    row.name      = name;
    row.keys      = k;
    row.hold      = hold;
    row.exp_count = exp_count;
    table_rows.push_back(row);
  endtask

  // ------------------------------
  // Stimulus table
  // ------------------------------
  task automatic fill_table();
    add_step("up_1",         2'b10, 4, 1);    // Key 0 counts up
    add_step("up_2",         2'b10, 4, 2);
    add_step("up_3",         2'b10, 4, 3);
    add_step("up_4",         2'b10, 4, 4);
    add_step("up_5",         2'b10, 4, 5);
    add_step("down_4",       2'b01, 4, 4);    // Key 1 counts down
    add_step("down_3",       2'b01, 4, 3);
    add_step("down_2",       2'b01, 4, 2);
    add_step("down_1",       2'b01, 4, 1);
    add_step("down_0",       2'b01, 4, 0);
    add_step("wrap_down",    2'b01, 4, 255);  // Below zero
    add_step("down_254",     2'b01, 4, 254);
    add_step("down_253",     2'b01, 4, 253);
    add_step("both_254",     2'b00, 4, 254);  // Up wins on a tie
    add_step("both_255",     2'b00, 4, 255);
    add_step("both_wrap",    2'b00, 4, 0);
    add_step("hold_up_1",    2'b10, 0, 1);    // Long random holds
    add_step("hold_up_2",    2'b10, 0, 2);
    add_step("hold_down_1",  2'b01, 0, 1);
    add_step("release_only", 2'b11, 0, 1);    // No key, no step
    add_step("mix_up_2",     2'b10, 3, 2);
    add_step("mix_up_3",     2'b10, 6, 3);
    add_step("mix_down_2",   2'b01, 3, 2);
    add_step("mix_up_3b",    2'b10, 0, 3);
    add_step("mix_both_4",   2'b00, 5, 4);
    add_step("mix_down_3",   2'b01, 0, 3);
    add_step("mix_up_4",     2'b10, 4, 4);
    add_step("mix_up_5",     2'b10, 7, 5);
    add_step("mix_down_4",   2'b01, 4, 4);
    add_step("mix_up_5b",    2'b10, 0, 5);
  endtask

  // One row, entered and left right after a falling edge
  task automatic apply_step(input step_t s);
    int          hold_cycles;
    int          elapsed;
    logic [7:0]  want_count;
    logic [20:0] want_hex;
    hold_cycles = (s.hold == 0) ? 5 + ($unsigned($random(seed)) % 36) : s.hold;
    want_count  = s.exp_count[7:0];
    want_hex    = expected_hex(s.exp_count);

    keys    = s.keys;                    // Press
    elapsed = 0;
    while (count !== want_count && elapsed < 10) begin
      @(negedge clk);
      elapsed++;
    end
    assert (count === want_count) else begin
      $display("Timeout: count did not reach %0d within 10 cycles in step %s",
               want_count, s.name);
      $display("Finished with errors");
      $fatal(1);
    end

    while (elapsed < hold_cycles) begin  // Keep holding
      @(negedge clk);
      elapsed++;
    end
    assert (count === want_count) else begin
      $display("[ERROR] %s: count while held, expected %0d, actual %0d",
               s.name, want_count, count);
      $display("Finished with errors");
      $fatal(1);
    end

    keys = 2'b11;                        // Release
    repeat (5) @(negedge clk);           // Longer than the sync path
    assert (count === want_count) else begin
      $display("[ERROR] %s: count after release, expected %0d, actual %0d",
               s.name, want_count, count);
      $display("Finished with errors");
      $fatal(1);
    end

    elapsed = 0;
    while (hex !== want_hex && elapsed < 200) begin
      @(negedge clk);
      elapsed++;
    end
    assert (hex === want_hex) else begin
      $display("Timeout: displays did not show %0d within 200 cycles in step %s",
               s.exp_count, s.name);
      $display("[ERROR] %s: hex expected %h, actual %h", s.name, want_hex, hex);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    seed  = 54820;
    reset = 1'b1;
    keys  = 2'b11;                       // Both keys released
    fill_table();

    repeat (16) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    assert (count === 8'd0) else begin
      $display("[ERROR] after_reset: count expected %0d, actual %0d", 0, count);
      $display("Finished with errors");
      $fatal(1);
    end
    assert (hex === expected_hex(0)) else begin
      $display("[ERROR] after_reset: hex expected %h, actual %h", expected_hex(0), hex);
      $display("Finished with errors");
      $fatal(1);
    end

    foreach (table_rows[i]) begin
      apply_step(table_rows[i]);
    end

    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: vlog.f
common/counter_display_pkg.sv
verilog/key_counter.sv
notation/seq_divider.sv
notation/decimal_converter.sv
verilog/seven_seg_decoder.sv
verilog/counter_display_top.sv
tb/counter_display_assertions.sv
tb/counter_display_tb.sv

// File: Makefile
TOP = counter_display_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f vlog.f -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
